// ==== all.f ====
+incdir+logic
logic/glb_pkg.sv
logic/glb_bank_if.sv
logic/glb_shift.sv
logic/glb_bank.sv
logic/glb_cfg_regs.sv
logic/glb_core_pc_dma.sv
logic/glb_pc_top.sv
verification/glb_pc_tb.sv

// ==== build.sh ====
#!/usr/bin/env bash
# Verilator build and run of the parallel-config global buffer testbench.
# Exits with a failing status unless the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module glb_pc_tb -f all.f --Mdir obj_dir -o glb_pc_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/glb_pc_sim > sim.log 2>&1 \
    || echo "simulator returned a failing status"

grep -qx ">>> PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== logic/glb_bank.sv ====
/* bank word memory, one write port fed from the apb window and one read port
   read data and its valid come back two cycles after the request */
`default_nettype none

module glb_bank (
    input  logic                                  clk,
    input  logic                                  reset,
    // write port, byte address
    input  logic                                  wr_en,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]    wr_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0]   wr_data,
    // read port
    glb_bank_if.bank                              rd
);

    import glb_pkg::*;

    localparam int WORD_ADDR_WIDTH = GLB_ADDR_WIDTH - BANK_ADDR_LSB;

    logic [BANK_DATA_WIDTH-1:0] mem [BANK_DEPTH];

    logic [WORD_ADDR_WIDTH-1:0] wr_word;
    logic [WORD_ADDR_WIDTH-1:0] rd_word;

    // first read stage
    logic rd_en_q;
    logic [WORD_ADDR_WIDTH-1:0] rd_word_q;

    // second read stage
    logic rd_valid_q;
    logic [BANK_DATA_WIDTH-1:0] rd_data_q;

    // byte offset inside a word is dropped
    assign wr_word = wr_addr[GLB_ADDR_WIDTH-1:BANK_ADDR_LSB];
    assign rd_word = rd.rd_addr[GLB_ADDR_WIDTH-1:BANK_ADDR_LSB];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_word] <= wr_data;
        end
    end

    // valid pipeline
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_en_q <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            rd_en_q <= rd.rd_en;
            rd_valid_q <= rd_en_q;
        end
    end

    // address then data
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            rd_word_q <= rd_word;
        end
        if (rd_en_q) begin
            rd_data_q <= mem[rd_word_q];
        end
    end

    // data and valid line up on the same cycle
    assign rd.rd_data = rd_data_q;
    assign rd.rd_data_valid = rd_valid_q;

endmodule

`default_nettype wire

// ==== logic/glb_bank_if.sv ====
/* fixed-latency read path between the parallel-config dma and the bank
   every rd_en is answered by one rd_data_valid two cycles later */
`default_nettype none

interface glb_bank_if;

    import glb_pkg::*;

    // request side, byte address
    logic rd_en;
    logic [GLB_ADDR_WIDTH-1:0] rd_addr;

    // response side
    logic [BANK_DATA_WIDTH-1:0] rd_data;
    logic rd_data_valid;

    modport dma (
        output rd_en,
        output rd_addr,
        input rd_data,
        input rd_data_valid
    );

    // mirror of dma
    modport bank (
        input rd_en,
        input rd_addr,
        output rd_data,
        output rd_data_valid
    );

endinterface

`default_nettype wire

// ==== logic/glb_cfg_regs.sv ====
/* apb slave for the dma registers, bank loading window, start command and status
   zero wait states, write staging for 64-bit bank words */
`default_nettype none

module glb_cfg_regs (
    input  logic                                  clk,
    input  logic                                  reset,
    // apb
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [glb_pkg::APB_ADDR_WIDTH-1:0]    paddr,
    input  logic [glb_pkg::APB_DATA_WIDTH-1:0]    pwdata,
    output logic [glb_pkg::APB_DATA_WIDTH-1:0]    prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    // to the dma
    output logic                                  cfg_pc_dma_mode,
    output glb_pkg::dma_pc_header_t               cfg_pc_dma_header,
    output logic [glb_pkg::LATENCY_WIDTH-1:0]     cfg_pc_latency,
    output logic                                  pc_start_pulse,
    // from the dma
    input  logic                                  pc_busy,
    input  logic                                  pc_done_pulse,
    // to the bank
    output logic                                  bank_wr_en,
    output logic [glb_pkg::GLB_ADDR_WIDTH-1:0]    bank_wr_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0]   bank_wr_data
);

    import glb_pkg::*;

    logic access;
    logic in_window;
    logic addr_ok;
    logic status_wr_bad;
    logic wr_ok;
    logic [APB_DATA_WIDTH-1:0] rdata;
    logic [APB_DATA_WIDTH-1:0] lo_stage;
    logic done_bit;
    logic done_pulse_d;

    assign access = psel & penable;
    // bank window covers the whole 4 KB above the base
    assign in_window = (paddr[APB_ADDR_WIDTH-1:GLB_ADDR_WIDTH] ==
                        BANK_WIN_BASE[APB_ADDR_WIDTH-1:GLB_ADDR_WIDTH]);

    // decode and read mux
    always_comb begin
        addr_ok = 1'b1;
        rdata = '0;
        if (!in_window) begin
            case (paddr)
                REG_MODE:       rdata = APB_DATA_WIDTH'(cfg_pc_dma_mode);
                REG_START_ADDR: rdata = APB_DATA_WIDTH'(cfg_pc_dma_header.start_addr);
                REG_NUM_CFGS:   rdata = APB_DATA_WIDTH'(cfg_pc_dma_header.num_cfgs);
                REG_LATENCY:    rdata = APB_DATA_WIDTH'(cfg_pc_latency);
                // write only
                REG_START:      rdata = '0;
                REG_STATUS:     rdata = APB_DATA_WIDTH'({done_bit, pc_busy});
                default:        addr_ok = 1'b0;
            endcase
        end
        // word aligned accesses only
        if (paddr[1:0] != 2'b00) begin
            addr_ok = 1'b0;
        end
    end

    // only bits 1 and 0 exist in status
    assign status_wr_bad = pwrite && (paddr == REG_STATUS) &&
                           (pwdata[APB_DATA_WIDTH-1:2] != '0);

    assign pready = access;
    assign pslverr = access & (~addr_ok | status_wr_bad);
    // bank window reads back as zero
    assign prdata = (access & ~pwrite) ? rdata : '0;
    assign wr_ok = access & pwrite & addr_ok & ~status_wr_bad;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_pc_dma_mode <= 1'b0;
            cfg_pc_dma_header <= '0;
            cfg_pc_latency <= '0;
            pc_start_pulse <= 1'b0;
            bank_wr_en <= 1'b0;
            done_bit <= 1'b0;
            done_pulse_d <= 1'b0;
        end else begin
            pc_start_pulse <= wr_ok && !in_window && (paddr == REG_START) && pwdata[0];
            // high half commits the staged word next cycle
            bank_wr_en <= wr_ok && in_window && paddr[2];
            done_pulse_d <= pc_done_pulse;
            if (wr_ok && !in_window) begin
                case (paddr)
                    REG_MODE:       cfg_pc_dma_mode <= pwdata[0];
                    REG_START_ADDR: cfg_pc_dma_header.start_addr <= pwdata[GLB_ADDR_WIDTH-1:0];
                    REG_NUM_CFGS:   cfg_pc_dma_header.num_cfgs <= pwdata[MAX_NUM_CFGS_WIDTH-1:0];
                    REG_LATENCY:    cfg_pc_latency <= pwdata[LATENCY_WIDTH-1:0];
                    default:        ;
                endcase
            end
            // sticky done, set wins over a clear in the same cycle
            if (pc_done_pulse && !done_pulse_d) begin
                done_bit <= 1'b1;
            end else if (wr_ok && !in_window && (paddr == REG_STATUS) && pwdata[1]) begin
                done_bit <= 1'b0;
            end
        end
    end

    // bank write payload
    always_ff @(posedge clk) begin
        if (wr_ok && in_window && !paddr[2]) begin
            lo_stage <= pwdata;
        end
        if (wr_ok && in_window && paddr[2]) begin
            bank_wr_addr <= {paddr[GLB_ADDR_WIDTH-1:BANK_ADDR_LSB], BANK_ADDR_LSB'(0)};
            bank_wr_data <= {pwdata, lo_stage};
        end
    end

endmodule

`default_nettype wire

// ==== logic/glb_core_pc_dma.sv ====
/* parallel-config dma that reads bank words one per cycle and emits array config writes
   a done flag runs through a fixed delay line and leaves as a fixed-width interrupt pulse */
`default_nettype none

module glb_core_pc_dma (
    input  logic                                  clk,
    input  logic                                  reset,
    // configuration
    input  logic                                  cfg_pc_dma_mode,
    input  glb_pkg::dma_pc_header_t               cfg_pc_dma_header,
    input  logic [glb_pkg::LATENCY_WIDTH-1:0]     cfg_pc_latency,
    input  logic                                  pc_start_pulse,
    // bank read path
    glb_bank_if.dma                               rd,
    // config write stream
    output logic                                  cfg_wr_en,
    output logic [glb_pkg::CFG_ADDR_WIDTH-1:0]    cfg_addr,
    output logic [glb_pkg::CFG_DATA_WIDTH-1:0]    cfg_data,
    // status
    output logic                                  pc_busy,
    output logic                                  pc_done_pulse
);

    import glb_pkg::*;

    pc_state_e state_q;
    logic start_ok;
    logic [MAX_NUM_CFGS_WIDTH-1:0] cnt_q;
    logic [GLB_ADDR_WIDTH-1:0] addr_q;
    logic issue;

    // registered request
    logic rd_en_q;
    logic [GLB_ADDR_WIDTH-1:0] rd_addr_q;

    // registered response
    logic rsp_valid_q;
    logic [BANK_DATA_WIDTH-1:0] rsp_data_q;

    // done pipeline
    logic done_flag;
    logic [0:0] done_taps [DONE_SHIFT_DEPTH];
    int pulse_base;

    // start only counts when enabled and idle
    assign start_ok = pc_start_pulse & cfg_pc_dma_mode & (state_q == PC_IDLE);
    // one read per cycle while words remain
    assign issue = (state_q == PC_RUN) && (cnt_q != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= PC_IDLE;
            cnt_q <= '0;
            addr_q <= '0;
            rd_en_q <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            rd_en_q <= 1'b0;
            done_flag <= 1'b0;
            case (state_q)
                PC_IDLE: begin
                    if (start_ok) begin
                        state_q <= PC_RUN;
                        cnt_q <= cfg_pc_dma_header.num_cfgs;
                        addr_q <= cfg_pc_dma_header.start_addr;
                    end
                end
                PC_RUN: begin
                    if (issue) begin
                        rd_en_q <= 1'b1;
                        cnt_q <= cnt_q - 1'b1;
                        // wraps at the bank end
                        addr_q <= addr_q + GLB_ADDR_WIDTH'(BANK_DATA_BYTE);
                    end else begin
                        // count hit zero last cycle
                        state_q <= PC_IDLE;
                        done_flag <= 1'b1;
                    end
                end
                default: state_q <= PC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            rd_addr_q <= addr_q;
        end
    end

    assign rd.rd_en = rd_en_q;
    assign rd.rd_addr = rd_addr_q;

    // response stage, no back-pressure
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd.rd_data_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd.rd_data_valid) begin
            rsp_data_q <= rd.rd_data;
        end
    end

    // upper half is the array address
    assign cfg_wr_en = rsp_valid_q;
    assign cfg_addr = rsp_data_q[CFG_DATA_WIDTH +: CFG_ADDR_WIDTH];
    assign cfg_data = rsp_data_q[CFG_DATA_WIDTH-1:0];

    assign pc_busy = (state_q == PC_RUN);

    // stands in for the tile chain delay
    glb_shift #(
        .DATA_WIDTH(1),
        .DEPTH(DONE_SHIFT_DEPTH)
    ) done_shift (
        .clk(clk),
        .reset(reset),
        .data_in(done_flag),
        .data_out(done_taps)
    );

    // first tap of the pulse window
    assign pulse_base = FIXED_LATENCY + LAT_STEP * int'(cfg_pc_latency);

    // window of INTERRUPT_PULSE taps
    always_comb begin
        pc_done_pulse = 1'b0;
        for (int i = 0; i < INTERRUPT_PULSE; i++) begin
            pc_done_pulse = pc_done_pulse | done_taps[pulse_base + i][0];
        end
    end

endmodule

`default_nettype wire

// ==== logic/glb_pc_top.sv ====
/* global buffer tile slice with parallel configuration
   apb host port in, array config writes and done interrupt out */
`default_nettype none

module glb_pc_top (
    input  logic                                  clk,
    input  logic                                  reset,
    // apb host port
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [glb_pkg::APB_ADDR_WIDTH-1:0]    paddr,
    input  logic [glb_pkg::APB_DATA_WIDTH-1:0]    pwdata,
    output logic [glb_pkg::APB_DATA_WIDTH-1:0]    prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    // config write stream
    output logic                                  cfg_wr_en,
    output logic [glb_pkg::CFG_ADDR_WIDTH-1:0]    cfg_addr,
    output logic [glb_pkg::CFG_DATA_WIDTH-1:0]    cfg_data,
    // interrupt
    output logic                                  pc_done_pulse
);

    import glb_pkg::*;

    // register block to dma
    logic cfg_pc_dma_mode;
    dma_pc_header_t cfg_pc_dma_header;
    logic [LATENCY_WIDTH-1:0] cfg_pc_latency;
    logic pc_start_pulse;
    logic pc_busy;

    // register block to bank
    logic bank_wr_en;
    logic [GLB_ADDR_WIDTH-1:0] bank_wr_addr;
    logic [BANK_DATA_WIDTH-1:0] bank_wr_data;

    glb_bank_if bank_rd ();

    glb_cfg_regs cfg_regs (
        .clk(clk),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .cfg_pc_dma_mode(cfg_pc_dma_mode),
        .cfg_pc_dma_header(cfg_pc_dma_header),
        .cfg_pc_latency(cfg_pc_latency),
        .pc_start_pulse(pc_start_pulse),
        .pc_busy(pc_busy),
        .pc_done_pulse(pc_done_pulse),
        .bank_wr_en(bank_wr_en),
        .bank_wr_addr(bank_wr_addr),
        .bank_wr_data(bank_wr_data)
    );

    glb_bank bank (
        .clk(clk),
        .reset(reset),
        .wr_en(bank_wr_en),
        .wr_addr(bank_wr_addr),
        .wr_data(bank_wr_data),
        .rd(bank_rd.bank)
    );

    glb_core_pc_dma pc_dma (
        .clk(clk),
        .reset(reset),
        .cfg_pc_dma_mode(cfg_pc_dma_mode),
        .cfg_pc_dma_header(cfg_pc_dma_header),
        .cfg_pc_latency(cfg_pc_latency),
        .pc_start_pulse(pc_start_pulse),
        .rd(bank_rd.dma),
        .cfg_wr_en(cfg_wr_en),
        .cfg_addr(cfg_addr),
        .cfg_data(cfg_data),
        .pc_busy(pc_busy),
        .pc_done_pulse(pc_done_pulse)
    );

endmodule

`default_nettype wire

// ==== logic/glb_pkg.sv ====
/* shared widths, register map and types for the parallel-config global buffer slice
   imported by every design module and by the testbench */
`default_nettype none

package glb_pkg;

    // bank geometry
    localparam int BANK_DATA_WIDTH = 64;
    localparam int BANK_DEPTH = 512;
    localparam int GLB_ADDR_WIDTH = 12;
    localparam int BANK_DATA_BYTE = 8;
    localparam int BANK_ADDR_LSB = $clog2(BANK_DATA_BYTE);

    // one bank word splits into array address and data
    localparam int CFG_ADDR_WIDTH = 32;
    localparam int CFG_DATA_WIDTH = 32;

    // dma header fields
    localparam int MAX_NUM_CFGS_WIDTH = 10;
    localparam int LATENCY_WIDTH = 3;

    // done pipeline
    localparam int FIXED_LATENCY = 7;
    localparam int LAT_STEP = 3;
    localparam int INTERRUPT_PULSE = 4;
    // longest delay plus the pulse itself
    localparam int DONE_SHIFT_DEPTH =
        FIXED_LATENCY + LAT_STEP * ((1 << LATENCY_WIDTH) - 1) + INTERRUPT_PULSE;

    // host port
    localparam int APB_ADDR_WIDTH = 16;
    localparam int APB_DATA_WIDTH = 32;

    // register map, byte offsets
    localparam logic [APB_ADDR_WIDTH-1:0] REG_MODE = 16'h0000;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_START_ADDR = 16'h0004;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_NUM_CFGS = 16'h0008;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_LATENCY = 16'h000C;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_START = 16'h0010;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS = 16'h0014;
    // 8 bytes per bank word, low half first
    localparam logic [APB_ADDR_WIDTH-1:0] BANK_WIN_BASE = 16'h1000;

    typedef struct packed {
        logic [GLB_ADDR_WIDTH-1:0] start_addr;
        logic [MAX_NUM_CFGS_WIDTH-1:0] num_cfgs;
    } dma_pc_header_t;

    typedef enum logic {
        PC_IDLE,
        PC_RUN
    } pc_state_e;

endpackage

`default_nettype wire

// ==== logic/glb_shift.sv ====
/* plain shift pipeline with every stage visible
   tap i carries data_in delayed by i+1 cycles */
`default_nettype none

module glb_shift #(
    parameter int DATA_WIDTH = 1,
    parameter int DEPTH = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [DATA_WIDTH-1:0]  data_in,
    output logic [DATA_WIDTH-1:0]  data_out [DEPTH]
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                data_out[i] <= '0;
            end
        end else begin
            data_out[0] <= data_in;
            // each tap takes the one before
            for (int i = 1; i < DEPTH; i++) begin
                data_out[i] <= data_out[i-1];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/glb_pc_tb.sv ====
/* self-checking testbench for the parallel-config global buffer slice
   drives the apb host port and checks the config stream, done pulse and status */
`default_nettype none

module glb_pc_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import glb_pkg::*;

    logic clk = 1'b0;
    logic reset;

    // apb host port
    logic psel;
    logic penable;
    logic pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic pready;
    logic pslverr;

    // config stream and interrupt
    logic cfg_wr_en;
    logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
    logic [CFG_DATA_WIDTH-1:0] cfg_data;
    logic pc_done_pulse;

    // shadow bank and expected stream
    logic [BANK_DATA_WIDTH-1:0] shadow [BANK_DEPTH];
    logic [CFG_ADDR_WIDTH-1:0] exp_addr [1 << MAX_NUM_CFGS_WIDTH];
    logic [CFG_DATA_WIDTH-1:0] exp_data [1 << MAX_NUM_CFGS_WIDTH];
    int exp_len = 0;
    int wr_base = 0;

    // monitor state, each owned by one process
    int cycle = 0;
    int cycle_budget = 40;
    int wr_total = 0;
    int first_wr_cyc = 0;
    int last_wr_cyc = 0;
    int pulse_total = 0;
    int pulse_width = 0;
    int pulse_start_cyc = 0;
    int cfg_errors = 0;
    int pulse_errors = 0;

    // main process bookkeeping
    int errors = 0;
    int tests = 0;
    int failed_tests = 0;
    int test_err_base = 0;
    logic [31:0] lfsr;

    glb_pc_top dut0 (
        .clk(clk),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .cfg_wr_en(cfg_wr_en),
        .cfg_addr(cfg_addr),
        .cfg_data(cfg_data),
        .pc_done_pulse(pc_done_pulse)
    );

    // 4 ns period
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // reference model: words from start_word on, wrapping at the bank end
    // upper half is the array address, lower half the data
    function automatic void build_expected(input int start_word, input int n);
        int w;
        for (int k = 0; k < n; k++) begin
            w = (start_word + k) % BANK_DEPTH;
            exp_addr[k] = shadow[w][BANK_DATA_WIDTH-1:CFG_DATA_WIDTH];
            exp_data[k] = shadow[w][CFG_DATA_WIDTH-1:0];
        end
        exp_len = n;
    endfunction

    function automatic int total_errors();
        return errors + cfg_errors + pulse_errors;
    endfunction

    task automatic note_failure(input string msg, inout int errs);
        $display("ERROR t=%0t %s", $time, msg);
        errs++;
    endtask

    task automatic check_cfg(
        input logic [CFG_ADDR_WIDTH-1:0] got_addr,
        input logic [CFG_DATA_WIDTH-1:0] got_data,
        input logic [CFG_ADDR_WIDTH-1:0] want_addr,
        input logic [CFG_DATA_WIDTH-1:0] want_data,
        inout int errs
    );
        if (got_addr !== want_addr) begin
            $display("MISMATCH t=%0t cfg_addr got %h expected %h", $time, got_addr, want_addr);
            errs++;
        end
        if (got_data !== want_data) begin
            $display("MISMATCH t=%0t cfg_data got %h expected %h", $time, got_data, want_data);
            errs++;
        end
    endtask

    task automatic check_apb(
        input string what,
        input logic [APB_DATA_WIDTH-1:0] got_data,
        input logic got_err,
        input logic [APB_DATA_WIDTH-1:0] want_data,
        input logic want_err,
        inout int errs
    );
        if (got_data !== want_data) begin
            $display("MISMATCH t=%0t prdata (%s) got %h expected %h",
                     $time, what, got_data, want_data);
            errs++;
        end
        if (got_err !== want_err) begin
            $display("MISMATCH t=%0t pslverr (%s) got %b expected %b",
                     $time, what, got_err, want_err);
            errs++;
        end
    endtask

    task automatic check_pulse(input int width, inout int errs);
        if (width != INTERRUPT_PULSE) begin
            $display("MISMATCH t=%0t pc_done_pulse width got %0d expected %0d",
                     $time, width, INTERRUPT_PULSE);
            errs++;
        end
    endtask

    // every config write against the expected list, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && cfg_wr_en) begin
            if (wr_total - wr_base < exp_len) begin
                check_cfg(cfg_addr, cfg_data, exp_addr[wr_total - wr_base],
                          exp_data[wr_total - wr_base], cfg_errors);
            end else begin
                note_failure("config write outside the expected stream", cfg_errors);
            end
            if (wr_total == wr_base) begin
                first_wr_cyc = cycle;
            end
            last_wr_cyc = cycle;
            wr_total++;
        end
    end

    // pulse start and width
    always @(negedge clk) begin
        if (!reset && pc_done_pulse) begin
            if (pulse_width == 0) begin
                pulse_start_cyc = cycle;
            end
            pulse_width++;
        end else if (pulse_width != 0) begin
            check_pulse(pulse_width, pulse_errors);
            pulse_total++;
            pulse_width = 0;
        end
    end

    // budget grows with each test
    initial begin
        wait (cycle > cycle_budget);
        $display("watchdog: run exceeded %0d cycles", cycle_budget);
        $display(">>> FAIL");
        $finish;
    end

    // inputs change 0.5 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic apb_write(
        input logic [APB_ADDR_WIDTH-1:0] addr,
        input logic [APB_DATA_WIDTH-1:0] data,
        output logic err
    );
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        next_cycle();
        penable = 1'b1;
        @(negedge clk);
        err = pslverr;
        if (pready !== 1'b1) begin
            note_failure("pready low in the access phase", errors);
        end
        next_cycle();
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(
        input logic [APB_ADDR_WIDTH-1:0] addr,
        output logic [APB_DATA_WIDTH-1:0] data,
        output logic err
    );
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        next_cycle();
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        err = pslverr;
        next_cycle();
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // low half first, high half commits
    task automatic load_bank();
        logic err;
        logic [APB_ADDR_WIDTH-1:0] slot;
        for (int w = 0; w < BANK_DEPTH; w++) begin
            shadow[w] = rand_bits(64);
            slot = BANK_WIN_BASE + APB_ADDR_WIDTH'(w * BANK_DATA_BYTE);
            apb_write(slot, shadow[w][CFG_DATA_WIDTH-1:0], err);
            apb_write(slot + 16'h4, shadow[w][BANK_DATA_WIDTH-1:CFG_DATA_WIDTH], err);
        end
    endtask

    task automatic wait_pulse(input int target, input int limit);
        int waited;
        waited = 0;
        while (pulse_total < target && waited < limit) begin
            next_cycle();
            waited++;
        end
        if (pulse_total < target) begin
            note_failure("timed out waiting for pc_done_pulse", errors);
        end
    endtask

    // one dma run, restart fires a second start with another header mid-run
    task automatic run_config(
        input int start_word,
        input int n,
        input int lat,
        input bit restart,
        output int gap
    );
        logic err;
        logic [APB_DATA_WIDTH-1:0] rd;
        int w0;
        int p0;
        int start_cyc;
        cycle_budget += 2 * (n + DONE_SHIFT_DEPTH) + 80;
        apb_write(REG_STATUS, 32'h2, err);
        apb_write(REG_START_ADDR, APB_DATA_WIDTH'(start_word * BANK_DATA_BYTE), err);
        apb_write(REG_NUM_CFGS, APB_DATA_WIDTH'(n), err);
        apb_write(REG_LATENCY, APB_DATA_WIDTH'(lat), err);
        build_expected(start_word, n);
        w0 = wr_total;
        p0 = pulse_total;
        wr_base = w0;
        apb_write(REG_START, 32'h1, err);
        start_cyc = cycle;
        if (restart) begin
            apb_write(REG_START_ADDR,
                      APB_DATA_WIDTH'(((start_word + 100) % BANK_DEPTH) * BANK_DATA_BYTE), err);
            apb_write(REG_NUM_CFGS, APB_DATA_WIDTH'(n / 2 + 1), err);
            apb_write(REG_START, 32'h1, err);
        end else if (n >= 8) begin
            apb_read(REG_STATUS, rd, err);
            check_apb("status busy", rd, err, 32'h1, 1'b0, errors);
        end
        wait_pulse(p0 + 1, n + DONE_SHIFT_DEPTH + 20);
        // quiet period, no second pulse or late writes
        repeat (DONE_SHIFT_DEPTH + 8) next_cycle();
        if (pulse_total != p0 + 1) begin
            note_failure($sformatf("%0d done pulses, expected 1", pulse_total - p0), errors);
        end
        if (wr_total - w0 != n) begin
            note_failure($sformatf("%0d config writes, expected %0d", wr_total - w0, n),
                         errors);
        end
        if (n > 0 && first_wr_cyc - start_cyc != 5) begin
            note_failure($sformatf("first config write %0d cycles after start, expected 5",
                                   first_wr_cyc - start_cyc), errors);
        end
        if (n > 0 && pulse_start_cyc <= last_wr_cyc) begin
            note_failure("done pulse started before the last config write", errors);
        end
        gap = pulse_start_cyc - last_wr_cyc;
        apb_read(REG_STATUS, rd, err);
        check_apb("status done", rd, err, 32'h2, 1'b0, errors);
    endtask

    task automatic begin_test();
        test_err_base = total_errors();
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        errs = total_errors() - test_err_base;
        tests++;
        if (errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", num, name, errs);
        end
    endtask

    initial begin
        int n;
        int sw;
        int gap0;
        int gap7;
        int w0;
        int p0;
        logic err;
        logic [APB_DATA_WIDTH-1:0] rd;
        logic [APB_DATA_WIDTH-1:0] val;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        lfsr = 32'hec4a_3309;
        repeat (10) @(posedge clk);
        #0.5;
        reset = 1'b0;
        next_cycle();

        // register readback, masked to field widths
        cycle_budget += 80;
        begin_test();
        val = APB_DATA_WIDTH'(rand_bits(32));
        apb_write(REG_MODE, val, err);
        apb_read(REG_MODE, rd, err);
        check_apb("mode", rd, err, val & 32'h1, 1'b0, errors);
        val = APB_DATA_WIDTH'(rand_bits(32));
        apb_write(REG_START_ADDR, val, err);
        apb_read(REG_START_ADDR, rd, err);
        check_apb("start addr", rd, err, val & 32'hfff, 1'b0, errors);
        val = APB_DATA_WIDTH'(rand_bits(32));
        apb_write(REG_NUM_CFGS, val, err);
        apb_read(REG_NUM_CFGS, rd, err);
        check_apb("num cfgs", rd, err, val & 32'h3ff, 1'b0, errors);
        val = APB_DATA_WIDTH'(rand_bits(32));
        apb_write(REG_LATENCY, val, err);
        apb_read(REG_LATENCY, rd, err);
        check_apb("latency", rd, err, val & 32'h7, 1'b0, errors);
        apb_read(16'h0040, rd, err);
        check_apb("unmapped", rd, err, 32'h0, 1'b1, errors);
        apb_write(REG_STATUS, 32'h4, err);
        if (err !== 1'b1) begin
            note_failure("status write beyond bit 1 gave no pslverr", errors);
        end
        end_test(1, "register readback");

        // full bank load, stream wraps at the bank end
        cycle_budget += 5 * BANK_DEPTH;
        begin_test();
        apb_write(REG_MODE, 32'h1, err);
        load_bank();
        n = 16 + int'(rand_bits(6));
        sw = BANK_DEPTH - n / 2;
        run_config(sw, n, int'(rand_bits(3)), 1'b0, gap0);
        end_test(2, "config stream");

        begin_test();
        n = 8 + int'(rand_bits(5));
        sw = int'(rand_bits(9));
        run_config(sw, n, int'(rand_bits(3)), 1'b0, gap0);
        apb_write(REG_STATUS, 32'h2, err);
        apb_read(REG_STATUS, rd, err);
        check_apb("status cleared", rd, err, 32'h0, 1'b0, errors);
        end_test(3, "done pulse and status");

        // mode 0 start must do nothing
        cycle_budget += 2 * DONE_SHIFT_DEPTH + 60;
        begin_test();
        apb_write(REG_MODE, 32'h0, err);
        apb_write(REG_NUM_CFGS, 32'h8, err);
        exp_len = 0;
        wr_base = wr_total;
        w0 = wr_total;
        p0 = pulse_total;
        apb_write(REG_START, 32'h1, err);
        repeat (DONE_SHIFT_DEPTH + 20) next_cycle();
        if (wr_total != w0 || pulse_total != p0) begin
            note_failure("start with mode 0 produced activity", errors);
        end
        apb_write(REG_MODE, 32'h1, err);
        n = 32 + int'(rand_bits(5));
        sw = int'(rand_bits(9));
        run_config(sw, n, int'(rand_bits(3)), 1'b1, gap0);
        end_test(4, "start gating");

        begin_test();
        sw = int'(rand_bits(9));
        run_config(sw, 0, int'(rand_bits(3)), 1'b0, gap0);
        end_test(5, "zero count");

        // same run at both latency extremes
        begin_test();
        n = 8 + int'(rand_bits(4));
        sw = int'(rand_bits(9));
        run_config(sw, n, 0, 1'b0, gap0);
        run_config(sw, n, 7, 1'b0, gap7);
        if (gap7 - gap0 != LAT_STEP * 7) begin
            note_failure($sformatf("latency 7 added %0d cycles, expected %0d",
                                   gap7 - gap0, LAT_STEP * 7), errors);
        end
        end_test(6, "latency settings");

        $display("summary: %0d tests, %0d failed, %0d errors",
                 tests, failed_tests, total_errors());
        if (total_errors() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
